//--- buffer_params.svh
// sizing macros for the multi-bank sample capture buffer
// include wherever a width or depth is needed
`ifndef BUFFER_PARAMS_SVH
`define BUFFER_PARAMS_SVH

// bits per sample and samples per beat
`define SAMPLE_WIDTH 16
`define PARALLEL_SAMPLES 2
`define BEAT_WIDTH (`SAMPLE_WIDTH * `PARALLEL_SAMPLES)

// beats per bank and number of banks
`define BANK_DEPTH 64
`define N_BANKS 4

// RAM address, beat count 0..BANK_DEPTH
`define ADDR_WIDTH $clog2(`BANK_DEPTH)
`define COUNT_WIDTH $clog2(`BANK_DEPTH + 1)

// bank index 0..N_BANKS-1, bank count 1..N_BANKS
`define BANK_IDX_WIDTH $clog2(`N_BANKS)
`define BANK_CNT_WIDTH $clog2(`N_BANKS + 1)

`endif

//--- sample_pkg.sv
// data path types shared by the banks, the readout mux and the top level
`include "buffer_params.svh"

package sample_pkg;

  typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

  // count header, beat count in the low bits
  typedef struct packed {
    logic [`BEAT_WIDTH-`COUNT_WIDTH-1:0] pad;
    logic [`COUNT_WIDTH-1:0]             count;
  } header_t;

  // a readout word is either samples or a header
  typedef union packed {
    sample_t [`PARALLEL_SAMPLES-1:0] samples;
    header_t                         header;
  } sample_word_t;

  // one stream beat, valid and ready travel beside it
  typedef struct packed {
    sample_word_t data;
    logic         last;
  } stream_beat_t;

endpackage

//--- capture_pkg.sv
// control and status types between the config block, the banks and the mux
`include "buffer_params.svh"

package capture_pkg;

  typedef struct packed {
    logic                        arm;        // one-cycle clear of the banks
    logic                        capturing;
    logic                        reading;
    logic [`BANK_CNT_WIDTH-1:0]  active_banks;
  } capture_ctrl_t;

  // per bank
  typedef struct packed {
    logic full;
    logic done;  // last readout word sent
  } bank_status_t;

endpackage

//--- buffer_config_regs.sv
// configuration registers and phase sequencing of the capture buffer
// turns start/stop pulses into arm, capture and readout levels
`include "buffer_params.svh"

module buffer_config_regs import capture_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic                       stop,
  input  logic                       cfg_write,
  input  logic [`BANK_CNT_WIDTH-1:0] cfg_active_banks,
  input  logic                       last_bank_full,
  input  logic                       readout_done,
  output capture_ctrl_t              ctrl,
  output logic                       full
);

  localparam logic [`BANK_CNT_WIDTH-1:0] MAX_BANKS = `N_BANKS;
  localparam logic [`BANK_CNT_WIDTH-1:0] ONE_BANK = 1;

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_CAPTURE,
    PH_READOUT
  } phase_t;

  phase_t                     phase;
  logic [`BANK_CNT_WIDTH-1:0] cfg_clamped;

  // keep the bank count in 1..N_BANKS
  always_comb begin
    if (cfg_active_banks == '0) begin
      cfg_clamped = ONE_BANK;
    end else if (cfg_active_banks > MAX_BANKS) begin
      cfg_clamped = MAX_BANKS;
    end else begin
      cfg_clamped = cfg_active_banks;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase             <= PH_IDLE;
      ctrl.arm          <= 1'b0;
      ctrl.capturing    <= 1'b0;
      ctrl.reading      <= 1'b0;
      ctrl.active_banks <= MAX_BANKS;
      full              <= 1'b0;
    end else begin
      ctrl.arm <= 1'b0;
      case (phase)
        PH_IDLE: begin
          if (cfg_write) begin
            ctrl.active_banks <= cfg_clamped;
          end
          if (start) begin
            ctrl.arm <= 1'b1;
            full     <= 1'b0;
            phase    <= PH_CAPTURE;
          end
        end
        PH_CAPTURE: begin
          // bank status is stale until arm has cleared the banks
          if (stop || (ctrl.capturing && last_bank_full)) begin
            ctrl.capturing <= 1'b0;
            ctrl.reading   <= 1'b1;
            full           <= ctrl.capturing && last_bank_full;
            phase          <= PH_READOUT;
          end else if (ctrl.arm) begin
            ctrl.capturing <= 1'b1;
          end
        end
        PH_READOUT: begin
          if (readout_done) begin
            ctrl.reading <= 1'b0;
            phase        <= PH_IDLE;
          end
        end
        default: begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

endmodule

//--- sample_buffer_bank.sv
// one capture bank: stores beats in a RAM while selected, then reads out
// a count header followed by the stored beats
`include "buffer_params.svh"

module sample_buffer_bank import sample_pkg::*, capture_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  capture_ctrl_t ctrl,
  input  logic          write_en,
  input  sample_word_t  write_beat,
  output bank_status_t  status,
  output logic          read_valid,
  output sample_word_t  read_word,
  input  logic          read_ready
);

  sample_word_t mem [`BANK_DEPTH];

  logic [`COUNT_WIDTH-1:0] count;
  logic [`COUNT_WIDTH-1:0] rd_addr;   // data words issued to the RAM
  logic                    hdr_sent;
  logic                    mem_v;     // RAM output register holds a word
  logic                    done;
  sample_word_t            mem_q;
  sample_word_t            hdr_word;

  logic accept;
  logic out_free;
  logic load_hdr;
  logic mem_to_out;
  logic issue;
  logic final_xfer;

  assign accept = write_en && (count != `BANK_DEPTH);

  // header view of the readout word
  always_comb begin
    hdr_word = '0;
    hdr_word.header.count = count;
  end

  // output register is empty or drains on this edge
  assign out_free   = !read_valid || read_ready;
  assign load_hdr   = ctrl.reading && !hdr_sent && out_free;
  assign mem_to_out = hdr_sent && mem_v && out_free;

  // prefetch next beat while the RAM output register is free
  assign issue = ctrl.reading && (rd_addr != count) && (!mem_v || mem_to_out);

  // nothing left behind the word that transfers now
  assign final_xfer = read_valid && read_ready && hdr_sent && !mem_v &&
                      (rd_addr == count);

  // RAM with one-cycle registered read
  always_ff @(posedge clk) begin
    if (accept) begin
      mem[count[`ADDR_WIDTH-1:0]] <= write_beat;
    end
    if (issue) begin
      mem_q <= mem[rd_addr[`ADDR_WIDTH-1:0]];
    end
  end

  // output data register
  always_ff @(posedge clk) begin
    if (load_hdr) begin
      read_word <= hdr_word;
    end else if (mem_to_out) begin
      read_word <= mem_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || ctrl.arm) begin
      count      <= '0;
      rd_addr    <= '0;
      hdr_sent   <= 1'b0;
      mem_v      <= 1'b0;
      read_valid <= 1'b0;
      done       <= 1'b0;
    end else begin
      if (accept) begin
        count <= count + 1'b1;
      end
      if (load_hdr) begin
        hdr_sent <= 1'b1;
      end
      if (issue) begin
        rd_addr <= rd_addr + 1'b1;
        mem_v   <= 1'b1;
      end else if (mem_to_out) begin
        mem_v <= 1'b0;
      end
      if (load_hdr || mem_to_out) begin
        read_valid <= 1'b1;
      end else if (read_ready) begin
        read_valid <= 1'b0;
      end
      if (final_xfer) begin
        done <= 1'b1;
      end
    end
  end

  assign status.full = (count == `BANK_DEPTH);
  assign status.done = done;

endmodule

//--- bank_readout_mux.sv
// steers capture writes from bank to bank, then merges the bank readouts
// into a single output stream with one last
`include "buffer_params.svh"

module bank_readout_mux import sample_pkg::*, capture_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  capture_ctrl_t       ctrl,
  input  logic                in_valid,
  input  stream_beat_t        in_beat,
  output logic                in_ready,
  input  bank_status_t        status [`N_BANKS],
  output logic [`N_BANKS-1:0] write_en,
  output sample_word_t        write_beat,
  input  logic [`N_BANKS-1:0] read_valid,
  input  sample_word_t        read_word [`N_BANKS],
  output logic [`N_BANKS-1:0] read_ready,
  output logic                out_valid,
  output stream_beat_t        out_beat,
  input  logic                out_ready,
  output logic                last_bank_full,
  output logic                readout_done
);

  logic [`BANK_IDX_WIDTH-1:0] wr_idx;
  logic [`BANK_IDX_WIDTH-1:0] rd_idx;
  logic [`BANK_IDX_WIDTH-1:0] last_idx;
  logic [`BANK_CNT_WIDTH-1:0] active_m1;
  logic                       hdr_pending;  // next word of rd_idx is its header
  logic [`COUNT_WIDTH-1:0]    remaining;
  sample_word_t               sel_word;
  logic                       final_word;
  logic                       xfer;

  assign active_m1      = ctrl.active_banks - 1'b1;
  assign last_idx       = active_m1[`BANK_IDX_WIDTH-1:0];
  assign last_bank_full = status[last_idx].full;

  // capture side, stall while the selected bank is full
  assign in_ready   = ctrl.capturing && !status[wr_idx].full;
  assign write_beat = in_beat.data;

  always_comb begin
    for (int i = 0; i < `N_BANKS; i++) begin
      write_en[i]   = in_valid && in_ready && (wr_idx == i);
      read_ready[i] = ctrl.reading && out_ready && (rd_idx == i);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || ctrl.arm) begin
      wr_idx <= '0;
    end else if (ctrl.capturing && status[wr_idx].full && (wr_idx != last_idx)) begin
      wr_idx <= wr_idx + 1'b1;
    end
  end

  // readout side
  assign sel_word  = read_word[rd_idx];
  assign out_valid = ctrl.reading && read_valid[rd_idx];
  assign xfer      = out_valid && out_ready;

  // an empty bank ends on its header
  assign final_word = hdr_pending ? (sel_word.header.count == '0) : (remaining == 1);

  always_comb begin
    out_beat.data = sel_word;
    out_beat.last = final_word && (rd_idx == last_idx);
  end

  assign readout_done = xfer && out_beat.last;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_idx      <= '0;
      hdr_pending <= 1'b1;
      remaining   <= '0;
    end else if (!ctrl.reading) begin
      rd_idx      <= '0;
      hdr_pending <= 1'b1;
    end else if (status[rd_idx].done && (rd_idx != last_idx)) begin
      rd_idx      <= rd_idx + 1'b1;
      hdr_pending <= 1'b1;
    end else if (xfer) begin
      if (hdr_pending) begin
        hdr_pending <= 1'b0;
        remaining   <= sel_word.header.count;
      end else begin
        remaining <= remaining - 1'b1;
      end
    end
  end

endmodule

//--- sample_buffer.sv
// top level of the multi-bank capture buffer
// config block, N_BANKS banks and the readout mux
`include "buffer_params.svh"

module sample_buffer import sample_pkg::*, capture_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic                       stop,
  input  logic                       cfg_write,
  input  logic [`BANK_CNT_WIDTH-1:0] cfg_active_banks,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  stream_beat_t               in_beat,
  output logic                       out_valid,
  input  logic                       out_ready,
  output stream_beat_t               out_beat,
  output logic                       full
);

  capture_ctrl_t       ctrl;
  bank_status_t        status [`N_BANKS];
  logic [`N_BANKS-1:0] write_en;
  logic [`N_BANKS-1:0] read_valid;
  logic [`N_BANKS-1:0] read_ready;
  sample_word_t        write_beat;
  sample_word_t        read_word [`N_BANKS];
  logic                last_bank_full;
  logic                readout_done;

  buffer_config_regs config_regs0 (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .stop             (stop),
    .cfg_write        (cfg_write),
    .cfg_active_banks (cfg_active_banks),
    .last_bank_full   (last_bank_full),
    .readout_done     (readout_done),
    .ctrl             (ctrl),
    .full             (full)
  );

  for (genvar i = 0; i < `N_BANKS; i++) begin : g_bank
    sample_buffer_bank bank0 (
      .clk        (clk),
      .reset      (reset),
      .ctrl       (ctrl),
      .write_en   (write_en[i]),
      .write_beat (write_beat),
      .status     (status[i]),
      .read_valid (read_valid[i]),
      .read_word  (read_word[i]),
      .read_ready (read_ready[i])
    );
  end

  bank_readout_mux mux0 (
    .clk            (clk),
    .reset          (reset),
    .ctrl           (ctrl),
    .in_valid       (in_valid),
    .in_beat        (in_beat),
    .in_ready       (in_ready),
    .status         (status),
    .write_en       (write_en),
    .write_beat     (write_beat),
    .read_valid     (read_valid),
    .read_word      (read_word),
    .read_ready     (read_ready),
    .out_valid      (out_valid),
    .out_beat       (out_beat),
    .out_ready      (out_ready),
    .last_bank_full (last_bank_full),
    .readout_done   (readout_done)
  );

endmodule

//--- sample_buffer_tb.sv
// testbench for the multi-bank sample capture buffer
// captures pseudo-random beats, reads them back and checks the merged stream
`include "buffer_params.svh"

module sample_buffer_tb import sample_pkg::*; ();

  // beats offered over all tests size the watchdog
  localparam int TOTAL_BEATS = 40 + 150 + 200 + 0 + 100;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 4 + 2000;

  logic                       clk;
  logic                       reset;
  logic                       start;
  logic                       stop;
  logic                       cfg_write;
  logic [`BANK_CNT_WIDTH-1:0] cfg_active_banks;
  logic                       in_valid;
  logic                       in_ready;
  stream_beat_t               in_beat;
  logic                       out_valid;
  logic                       out_ready;
  stream_beat_t               out_beat;
  logic                       full;

  logic [31:0]            rng;
  logic [`BEAT_WIDTH-1:0] sent_q [$];
  stream_beat_t           recv_q [$];
  int                     assert_errors;
  int                     tests_run;
  int                     tests_failed;

  sample_buffer dut0 (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .stop             (stop),
    .cfg_write        (cfg_write),
    .cfg_active_banks (cfg_active_banks),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .in_beat          (in_beat),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_beat         (out_beat),
    .full             (full)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // stalled output beat must hold until it transfers
  assert property (@(posedge clk) disable iff (reset)
                   out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
      assert_errors++;
      $display("output beat changed or dropped while out_ready was low");
    end

  assert property (@(posedge clk) full |-> !in_ready)
    else begin
      assert_errors++;
      $display("in_ready was high while full was set");
    end

  assert property (@(posedge clk) reset |=> !out_valid && !in_ready && !full)
    else begin
      assert_errors++;
      $display("a valid, ready or full output was high right after reset");
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic run_test(input string name, input int banks, input int max_beats,
                          input int exp_accept, input bit use_stop,
                          input bit late_cfg, input bit stalls);
    logic [`BEAT_WIDTH-1:0] exp_q [$];
    logic [`BEAT_WIDTH-1:0] hdr;
    int  errs_before;
    int  accepted;
    int  banks_eff;
    int  chunk;
    int  b;
    int  idx;
    bit  pending;
    bit  rx_done;
    bit  test_bad;
    errs_before = assert_errors;
    test_bad    = 1'b0;
    sent_q.delete();
    recv_q.delete();
    banks_eff = (banks < 1) ? 1 : ((banks > `N_BANKS) ? `N_BANKS : banks);

    // configure while idle and then arm
    cfg_write        = 1'b1;
    cfg_active_banks = banks[`BANK_CNT_WIDTH-1:0];
    next_cycle();
    cfg_write = 1'b0;
    start     = 1'b1;
    next_cycle();
    start = 1'b0;
    if (late_cfg) begin
      // capture is running so this write must not count
      cfg_write        = 1'b1;
      cfg_active_banks = 1;
    end
    next_cycle();
    cfg_write = 1'b0;

    // capture phase where the source holds a refused beat
    accepted = 0;
    pending  = 1'b0;
    while (accepted < max_beats && !full) begin
      if (!pending) begin
        rng          = xorshift32(rng);
        in_beat.data = rng[`BEAT_WIDTH-1:0];
        rng          = xorshift32(rng);
        pending      = !stalls || (rng[1:0] != 2'b00);
      end
      in_valid = pending;
      @(negedge clk);
      if (in_valid && in_ready) begin
        sent_q.push_back(in_beat.data);
        accepted++;
        pending = 1'b0;
      end
      next_cycle();
    end
    in_valid = 1'b0;
    if (use_stop) begin
      stop = 1'b1;
      next_cycle();
      stop = 1'b0;
    end

    // readout until the beat with last
    rx_done = 1'b0;
    while (!rx_done) begin
      rng       = xorshift32(rng);
      out_ready = !stalls || (rng[2:0] != 3'b000);
      @(negedge clk);
      if (out_valid && out_ready) begin
        recv_q.push_back(out_beat);
        rx_done = out_beat.last;
      end
      if (recv_q.size() > accepted + `N_BANKS) begin
        $display("%s: readout ran past the expected length without last", name);
        test_bad = 1'b1;
        rx_done  = 1'b1;
      end
      next_cycle();
    end
    out_ready = 1'b0;
    next_cycle();

    // expected stream has a header and then a chunk per active bank
    for (b = 0; b < banks_eff; b++) begin
      chunk = accepted - b * `BANK_DEPTH;
      if (chunk < 0) begin
        chunk = 0;
      end else if (chunk > `BANK_DEPTH) begin
        chunk = `BANK_DEPTH;
      end
      hdr = '0;
      hdr[`COUNT_WIDTH-1:0] = chunk[`COUNT_WIDTH-1:0];
      exp_q.push_back(hdr);
      for (idx = 0; idx < chunk; idx++) begin
        exp_q.push_back(sent_q[b * `BANK_DEPTH + idx]);
      end
    end

    assert (accepted == exp_accept) else begin
      $display("FAILED %s accepted beats expected %0d actual %0d", name, exp_accept, accepted);
      test_bad = 1'b1;
    end
    assert (full == (accepted == banks_eff * `BANK_DEPTH)) else begin
      $display("FAILED %s full expected %0b actual %0b", name,
               accepted == banks_eff * `BANK_DEPTH, full);
      test_bad = 1'b1;
    end
    assert (recv_q.size() == exp_q.size()) else begin
      $display("FAILED %s word count expected %0d actual %0d", name,
               exp_q.size(), recv_q.size());
      test_bad = 1'b1;
    end
    for (idx = 0; idx < exp_q.size() && idx < recv_q.size(); idx++) begin
      assert (recv_q[idx].data == exp_q[idx] &&
              recv_q[idx].last == (idx == exp_q.size() - 1)) else begin
        $display("FAILED %s word %0d expected %h last %0b actual %h last %0b", name, idx,
                 exp_q[idx], idx == exp_q.size() - 1, recv_q[idx].data, recv_q[idx].last);
        test_bad = 1'b1;
      end
    end

    if (assert_errors != errs_before) begin
      test_bad = 1'b1;
    end
    tests_run++;
    if (test_bad) begin
      tests_failed++;
    end
    $display("%-16s %s", name, test_bad ? "failed" : "ok");
  endtask

  initial begin
    reset            = 1'b1;
    start            = 1'b0;
    stop             = 1'b0;
    cfg_write        = 1'b0;
    cfg_active_banks = '0;
    in_valid         = 1'b0;
    in_beat          = '0;
    out_ready        = 1'b0;
    rng              = 32'hfd98_edeb;
    assert_errors    = 0;
    tests_run        = 0;
    tests_failed     = 0;
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;
    next_cycle();

    run_test("short_capture", 4, 40, 40, 1'b1, 1'b0, 1'b0);
    run_test("span_banks", 4, 150, 150, 1'b1, 1'b0, 1'b0);
    // runs until full without a stop pulse
    run_test("fill_two_banks", 2, 200, 2 * `BANK_DEPTH, 1'b0, 1'b0, 1'b0);
    run_test("start_stop", 4, 0, 0, 1'b1, 1'b0, 1'b0);
    run_test("stall_cfg", 3, 100, 100, 1'b1, 1'b1, 1'b1);

    $display("tests %0d, passed %0d, failed %0d", tests_run,
             tests_run - tests_failed, tests_failed);
    if (tests_failed == 0 && assert_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

//--- files.f
+incdir+.
sample_pkg.sv
capture_pkg.sv
buffer_config_regs.sv
sample_buffer_bank.sv
bank_readout_mux.sv
sample_buffer.sv
sample_buffer_tb.sv
